/* rv_core.f */
+incdir+sim
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_branch_cmp.sv
rtl/rv_ex_stage.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/rv_datapath.sv
rtl/rv_core.sv
sim/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --top-module rv_core_tb -f rv_core.f > build.log 2>&1 \
    && ./obj_dir/Vrv_core_tb > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
echo "simulation passed"

/* sim/rv_iss_model.svh */
localparam int          PROG_WORDS = 64;
localparam int          RAM_WORDS  = 64;
localparam logic [31:0] PROG_BYTES = 32'd256;
localparam logic [31:0] LFSR_SEED  = 32'h78ab_5d92;

typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
} reg_wr_t;

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
} store_t;

logic [31:0] lfsr_state;
logic [31:0] prog [PROG_WORDS];

// expected retirements in program order
reg_wr_t exp_wr [$];
store_t  exp_st [$];

// x^32 + x^22 + x^2 + x + 1
function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    next_bit = fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[30:0], next_bit()};
    end
    rand_bits = v;
endfunction

// start-up contents of the data RAM
function automatic logic [31:0] fill_word(input int idx);
    fill_word = 32'h3c5a_96e1 ^ (idx * 32'h0001_0003);
endfunction

function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] y;
    case (f3)
        3'b000: y = alt ? a - b : a + b;
        3'b001: y = a << b[4:0];
        3'b010: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: y = (a < b) ? 32'd1 : 32'd0;
        3'b100: y = a ^ b;
        3'b101: begin
            if (alt) begin
                y = $signed(a) >>> b[4:0];
            end else begin
                y = a >> b[4:0];
            end
        end
        3'b110: y = a | b;
        default: y = a & b;
    endcase
    alu_result = y;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'b000: branch_taken = (a == b);
        3'b001: branch_taken = (a != b);
        3'b100: branch_taken = ($signed(a) < $signed(b));
        3'b101: branch_taken = ($signed(a) >= $signed(b));
        3'b110: branch_taken = (a < b);
        3'b111: branch_taken = (a >= b);
        default: branch_taken = 1'b0;
    endcase
endfunction

// one instruction per step until pc leaves the program
task automatic run_model();
    logic [31:0] xr [32];
    logic [31:0] dmem [RAM_WORDS];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [4:0]  rd;
    logic        wr;
    reg_wr_t     w;
    store_t      s;
    for (int k = 0; k < 32; k++) begin
        xr[k] = '0;
    end
    for (int k = 0; k < RAM_WORDS; k++) begin
        dmem[k] = fill_word(k);
    end
    pc = rv_pkg::RESET_PC;
    while (pc < PROG_BYTES) begin
        ins     = prog[pc[7:2]];
        rd      = ins[11:7];
        a       = xr[ins[19:15]];
        b       = xr[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        wr      = 1'b0;
        res     = '0;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            rv_pkg::OPC_OP: begin
                res = alu_result(ins[14:12], ins[30], a, b);
                wr  = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                // only srai uses bit 30 as a selector
                res = alu_result(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
                wr  = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                res = {ins[31:12], 12'd0};
                wr  = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                addr = a + imm_i;
                res  = dmem[addr[7:2]];
                wr   = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                addr = a + imm_s;
                dmem[addr[7:2]] = b;
                s.addr = addr;
                s.data = b;
                exp_st.push_back(s);
            end
            rv_pkg::OPC_BRANCH: begin
                if (branch_taken(ins[14:12], a, b)) begin
                    next_pc = pc + imm_b;
                end
            end
            default: ;
        endcase
        if (wr && rd != 5'd0) begin
            xr[rd] = res;
            w.rd   = rd;
            w.data = res;
            exp_wr.push_back(w);
        end
        pc = next_pc;
    end
endtask

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    logic        clk;
    logic        reset_i;
    logic [31:0] rom_addr_o;
    logic [31:0] instr_i;
    logic [31:0] ram_addr_o;
    logic        r_en_o;
    logic        w_en_o;
    logic [31:0] store_data_o;
    logic [31:0] load_data_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    `include "rv_iss_model.svh"

    // beq x0, x0, 0
    localparam logic [31:0] LOOP_INSTR = 32'h0000_0063;
    // 64 instructions at up to 3 cycles each, plus drain and margin
    localparam int TIMEOUT_CYCLES = 400;
    localparam int END_CYCLES     = 6;

    logic [31:0] ram [RAM_WORDS];
    logic [31:0] load_q;
    int          cycle_cnt;
    int          loop_cycles;
    int          errors;
    int          wr_checked;
    int          st_checked;

    rv_core uut (
        .clk          (clk),
        .reset_i      (reset_i),
        .rom_addr_o   (rom_addr_o),
        .instr_i      (instr_i),
        .ram_addr_o   (ram_addr_o),
        .r_en_o       (r_en_o),
        .w_en_o       (w_en_o),
        .store_data_o (store_data_o),
        .load_data_i  (load_data_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // memories
    //////////////////////////////////////////////////

    // data RAM, load word handed over on the next falling edge
    initial begin
        load_q = '0;
        for (int k = 0; k < RAM_WORDS; k++) begin
            ram[k] = fill_word(k);
        end
        forever begin
            @(posedge clk);
            if (w_en_o === 1'b1) begin
                ram[ram_addr_o[7:2]] = store_data_o;
            end
            if (r_en_o === 1'b1) begin
                load_q = ram[ram_addr_o[7:2]];
            end
        end
    end

    initial begin
        instr_i     = LOOP_INSTR;
        load_data_i = '0;
        forever begin
            @(negedge clk);
            if (rom_addr_o < PROG_BYTES) begin
                instr_i = prog[rom_addr_o[7:2]];
            end else begin
                instr_i = LOOP_INSTR;
            end
            load_data_i = load_q;
        end
    end

    //////////////////////////////////////////////////
    // program generation
    //////////////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        enc_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
    endfunction

    // x0..x7 only, so dependencies come often
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = rand_bits(3);
        pick_reg = {2'b00, r[2:0]};
    endfunction

    task automatic build_program();
        logic [31:0] kind;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        for (int n = 0; n < PROG_WORDS; n++) begin
            rd   = pick_reg();
            rs1  = pick_reg();
            rs2  = pick_reg();
            kind = rand_bits(3);
            r    = rand_bits(24);
            f3   = r[2:0];
            if (n < 7) begin
                // give x1..x7 known values first
                prog[n] = enc_i(r[15:4], 5'd0, 3'b000, 5'(n + 1), rv_pkg::OPC_OP_IMM);
            end else begin
                case (kind[2:0])
                    3'd0, 3'd1: begin
                        prog[n] = enc_r((r[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                                        rs2, rs1, f3, rd);
                    end
                    3'd2, 3'd3: begin
                        imm = r[15:4];
                        if (f3 == 3'b001) begin
                            imm = {7'h00, r[8:4]};
                        end
                        if (f3 == 3'b101) begin
                            imm = {r[3] ? 7'h20 : 7'h00, r[8:4]};
                        end
                        prog[n] = enc_i(imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM);
                    end
                    3'd4: prog[n] = {r[23:4], rd, rv_pkg::OPC_LUI};
                    3'd5: begin
                        prog[n] = enc_i({7'd0, r[6:4], 2'b00}, r[7] ? 5'd0 : rs1, 3'b010, rd,
                                        rv_pkg::OPC_LOAD);
                    end
                    3'd6: prog[n] = enc_s({7'd0, r[6:4], 2'b00}, rs2, r[7] ? 5'd0 : rs1);
                    default: begin
                        // 010 and 011 folded onto bltu and bgeu
                        if (f3[2:1] == 2'b01) begin
                            f3[2] = 1'b1;
                        end
                        boff = 13'd8 + {9'd0, r[5:4], 2'b00};
                        prog[n] = enc_b(boff, rs2, rs1, f3);
                    end
                endcase
            end
        end
    endtask

    //////////////////////////////////////////////////
    // scoreboard
    //////////////////////////////////////////////////

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        errors++;
        $display("FAILED %s: got %h, expected %h", name, got, expected);
    endtask

    // called just before each rising edge settles the cycle
    task automatic check_outputs();
        reg_wr_t w;
        store_t  s;
        if (cycle_cnt == 0 && rom_addr_o !== rv_pkg::RESET_PC) begin
            flag_mismatch("rom_addr_o", rom_addr_o, rv_pkg::RESET_PC);
        end
        if (cycle_cnt < 2 && (r_en_o !== 1'b0 || w_en_o !== 1'b0)) begin
            errors++;
            $display("memory enable not low in cycle %0d after reset", cycle_cnt);
        end
        if (cycle_cnt < 3 && wb_valid_o !== 1'b0) begin
            errors++;
            $display("write-back valid not low in cycle %0d after reset", cycle_cnt);
        end
        if (wb_valid_o === 1'b1) begin
            if (exp_wr.size() == 0) begin
                errors++;
                $display("register write to x%0d that the model does not expect", wb_rd_o);
            end else begin
                w = exp_wr.pop_front();
                wr_checked++;
                if (wb_rd_o !== w.rd) begin
                    flag_mismatch("wb_rd_o", {27'd0, wb_rd_o}, {27'd0, w.rd});
                end
                if (wb_data_o !== w.data) begin
                    flag_mismatch("wb_data_o", wb_data_o, w.data);
                end
            end
        end
        if (w_en_o === 1'b1) begin
            if (exp_st.size() == 0) begin
                errors++;
                $display("store to address %h that the model does not expect", ram_addr_o);
            end else begin
                s = exp_st.pop_front();
                st_checked++;
                if (ram_addr_o !== s.addr) begin
                    flag_mismatch("ram_addr_o", ram_addr_o, s.addr);
                end
                if (store_data_o !== s.data) begin
                    flag_mismatch("store_data_o", store_data_o, s.data);
                end
            end
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        cycle_cnt   = 0;
        loop_cycles = 0;
        errors      = 0;
        wr_checked  = 0;
        st_checked  = 0;
        lfsr_state  = LFSR_SEED;
        build_program();
        run_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        while (loop_cycles < END_CYCLES && cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            check_outputs();
            cycle_cnt++;
            // past the program only the end loop is fetched
            if (rom_addr_o >= PROG_BYTES) begin
                loop_cycles++;
            end
        end

        if (loop_cycles < END_CYCLES) begin
            errors++;
            $display("timeout: end loop not reached within %0d cycles", TIMEOUT_CYCLES);
        end else begin
            if (exp_wr.size() != 0) begin
                errors++;
                $display("%0d register writes of the model never retired", exp_wr.size());
            end
            if (exp_st.size() != 0) begin
                errors++;
                $display("%0d stores of the model never appeared", exp_st.size());
            end
        end

        $display("register writes checked %0d, stores checked %0d, errors %0d",
                 wr_checked, st_checked, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic        clk,
    input  logic        reset_i,
    output logic [31:0] rom_addr_o,
    input  logic [31:0] instr_i,
    output logic [31:0] ram_addr_o,
    output logic        r_en_o,
    output logic        w_en_o,
    output logic [31:0] store_data_o,
    input  logic [31:0] load_data_i,
    output logic        wb_valid_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o
);

    rv_pkg::instr_u instr_id;
    rv_pkg::ctrl_t  ctrl_id;

    // control for the instruction sitting in ID
    rv_decoder u_decoder (
        .instr_i (instr_id),
        .ctrl_o  (ctrl_id)
    );

    rv_datapath u_datapath (
        .clk          (clk),
        .reset_i      (reset_i),
        .rom_addr_o   (rom_addr_o),
        .instr_i      (instr_i),
        .ram_addr_o   (ram_addr_o),
        .r_en_o       (r_en_o),
        .w_en_o       (w_en_o),
        .store_data_o (store_data_o),
        .load_data_i  (load_data_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .instr_id_o   (instr_id),
        .ctrl_id_i    (ctrl_id)
    );

endmodule

/* rtl/rv_datapath.sv */
`timescale 1ns/1ps

module rv_datapath (
    input  logic           clk,
    input  logic           reset_i,
    output logic [31:0]    rom_addr_o,
    input  logic [31:0]    instr_i,
    output logic [31:0]    ram_addr_o,
    output logic           r_en_o,
    output logic           w_en_o,
    output logic [31:0]    store_data_o,
    input  logic [31:0]    load_data_i,
    output logic           wb_valid_o,
    output logic [4:0]     wb_rd_o,
    output logic [31:0]    wb_data_o,
    output rv_pkg::instr_u instr_id_o,
    input  rv_pkg::ctrl_t  ctrl_id_i
);

    logic [rv_pkg::XLEN-1:0] pc;
    rv_pkg::if_id_t          if_id;
    rv_pkg::id_ex_t          id_ex;
    rv_pkg::ex_wb_t          ex_wb;
    rv_pkg::ex_out_t         ex_out;

    logic [rv_pkg::XLEN-1:0] imm_id;
    logic [rv_pkg::XLEN-1:0] rs1_data_id;
    logic [rv_pkg::XLEN-1:0] rs2_data_id;
    logic [rv_pkg::XLEN-1:0] wb_data;

    //////////////////////////////////////////////////
    // IF
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc <= rv_pkg::RESET_PC;
        end else if (ex_out.redirect) begin
            pc <= ex_out.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    assign rom_addr_o = pc;

    // taken branch in EX squashes IF and ID
    always_ff @(posedge clk) begin
        if_id.pc <= pc;
        if (reset_i || ex_out.redirect) begin
            if_id.instr <= rv_pkg::NOP_INSTR;
        end else begin
            if_id.instr <= instr_i;
        end
    end

    //////////////////////////////////////////////////
    // ID
    //////////////////////////////////////////////////

    assign instr_id_o = if_id.instr;

    always_comb begin
        case (ctrl_id_i.imm_sel)
            rv_pkg::IMM_I: imm_id = {{20{if_id.instr.i.imm12[11]}}, if_id.instr.i.imm12};
            rv_pkg::IMM_S: imm_id = {{20{if_id.instr.s.imm_hi[6]}}, if_id.instr.s.imm_hi,
                                     if_id.instr.s.imm_lo};
            rv_pkg::IMM_B: imm_id = {{20{if_id.instr.b.imm_12}}, if_id.instr.b.imm_11,
                                     if_id.instr.b.imm_10_5, if_id.instr.b.imm_4_1, 1'b0};
            // upper 20 bits sit above funct3
            default:       imm_id = {if_id.instr.r.funct7, if_id.instr.r.rs2,
                                     if_id.instr.r.rs1, if_id.instr.r.funct3, 12'd0};
        endcase
    end

    rv_regfile u_regfile (
        .clk      (clk),
        .raddr1_i (if_id.instr.r.rs1),
        .raddr2_i (if_id.instr.r.rs2),
        .rdata1_o (rs1_data_id),
        .rdata2_o (rs2_data_id),
        .we_i     (ex_wb.ctrl.reg_write),
        .waddr_i  (ex_wb.rd),
        .wdata_i  (wb_data)
    );

    always_ff @(posedge clk) begin
        id_ex.pc       <= if_id.pc;
        id_ex.rs1      <= if_id.instr.r.rs1;
        id_ex.rs2      <= if_id.instr.r.rs2;
        id_ex.rs1_data <= rs1_data_id;
        id_ex.rs2_data <= rs2_data_id;
        id_ex.rd       <= if_id.instr.r.rd;
        id_ex.imm      <= imm_id;
        id_ex.funct3   <= if_id.instr.r.funct3;
        if (reset_i || ex_out.redirect) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= ctrl_id_i;
        end
    end

    //////////////////////////////////////////////////
    // EX
    //////////////////////////////////////////////////

    rv_ex_stage u_ex_stage (
        .id_ex_i       (id_ex),
        .wb_fwd_we_i   (ex_wb.ctrl.reg_write),
        .wb_fwd_rd_i   (ex_wb.rd),
        .wb_fwd_data_i (wb_data),
        .ex_o          (ex_out)
    );

    assign ram_addr_o   = ex_out.result;
    assign r_en_o       = id_ex.ctrl.mem_read;
    assign w_en_o       = id_ex.ctrl.mem_write;
    assign store_data_o = ex_out.store_data;

    always_ff @(posedge clk) begin
        ex_wb.rd     <= id_ex.rd;
        ex_wb.result <= ex_out.result;
        if (reset_i) begin
            ex_wb.ctrl <= '0;
        end else begin
            ex_wb.ctrl <= id_ex.ctrl;
        end
    end

    //////////////////////////////////////////////////
    // WB
    //////////////////////////////////////////////////

    // load data shows up one cycle after r_en_o
    assign wb_data    = ex_wb.ctrl.mem_read ? load_data_i : ex_wb.result;
    assign wb_valid_o = ex_wb.ctrl.reg_write && (ex_wb.rd != 5'd0);
    assign wb_rd_o    = ex_wb.rd;
    assign wb_data_o  = wb_data;

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::instr_u instr_i,
    output rv_pkg::ctrl_t  ctrl_o
);

    // alt selects sub over add and sra over srl
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_sel = rv_pkg::ALU_SLL;
            3'b010:  alu_sel = rv_pkg::ALU_SLT;
            3'b011:  alu_sel = rv_pkg::ALU_SLTU;
            3'b100:  alu_sel = rv_pkg::ALU_XOR;
            3'b101:  alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_sel = rv_pkg::ALU_OR;
            default: alu_sel = rv_pkg::ALU_AND;
        endcase
    endfunction

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;
    logic       alt_ok;

    assign funct7  = instr_i.r.funct7;
    assign funct3  = instr_i.r.funct3;
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    // only add/sub and the right shifts have an alternate form
    assign alt_ok  = f7_alt && (funct3 == 3'b000 || funct3 == 3'b101);

    always_comb begin
        ctrl_o = '0;
        case (instr_i.r.opcode)
            rv_pkg::OPC_OP: begin
                if (f7_zero || alt_ok) begin
                    ctrl_o.alu_op    = alu_sel(funct3, funct7[5]);
                    ctrl_o.reg_write = 1'b1;
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                // shift immediates carry funct7 in the upper imm bits
                if (funct3 == 3'b001 && !f7_zero) begin
                    ctrl_o = '0;
                end else if (funct3 == 3'b101 && !(f7_zero || f7_alt)) begin
                    ctrl_o = '0;
                end else begin
                    ctrl_o.alu_op    = alu_sel(funct3, funct7[5] && funct3 == 3'b101);
                    ctrl_o.imm_sel   = rv_pkg::IMM_I;
                    ctrl_o.src_imm   = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                end
            end
            rv_pkg::OPC_LUI: begin
                ctrl_o.alu_op    = rv_pkg::ALU_PASS_B;
                ctrl_o.imm_sel   = rv_pkg::IMM_U;
                ctrl_o.src_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                // word access only
                if (funct3 == 3'b010) begin
                    ctrl_o.imm_sel   = rv_pkg::IMM_I;
                    ctrl_o.src_imm   = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.mem_read  = 1'b1;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl_o.imm_sel   = rv_pkg::IMM_S;
                    ctrl_o.src_imm   = 1'b1;
                    ctrl_o.mem_write = 1'b1;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    ctrl_o.imm_sel = rv_pkg::IMM_B;
                    ctrl_o.branch  = 1'b1;
                end
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so ID sees the value retiring in WB
    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

/* rtl/rv_ex_stage.sv */
`timescale 1ns/1ps

module rv_ex_stage (
    input  rv_pkg::id_ex_t  id_ex_i,
    input  logic            wb_fwd_we_i,
    input  logic [4:0]      wb_fwd_rd_i,
    input  logic [31:0]     wb_fwd_data_i,
    output rv_pkg::ex_out_t ex_o
);

    // take the value retiring in WB over the stale ID read
    function automatic logic [31:0] fwd(input logic [4:0] rs, input logic [31:0] data);
        if (wb_fwd_we_i && wb_fwd_rd_i != 5'd0 && wb_fwd_rd_i == rs) begin
            fwd = wb_fwd_data_i;
        end else begin
            fwd = data;
        end
    endfunction

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic        take;

    // load data arrives late in the cycle, so the WB inputs must retrigger this
    always_comb begin
        rs1_val = fwd(id_ex_i.rs1, id_ex_i.rs1_data);
        rs2_val = fwd(id_ex_i.rs2, id_ex_i.rs2_data);
    end

    assign alu_b   = id_ex_i.ctrl.src_imm ? id_ex_i.imm : rs2_val;

    rv_alu u_alu (
        .op_i (id_ex_i.ctrl.alu_op),
        .a_i  (rs1_val),
        .b_i  (alu_b),
        .y_o  (alu_y)
    );

    rv_branch_cmp u_branch_cmp (
        .funct3_i (id_ex_i.funct3),
        .a_i      (rs1_val),
        .b_i      (rs2_val),
        .take_o   (take)
    );

    // loads and stores run rs1 + imm through the adder
    assign ex_o.result     = alu_y;
    assign ex_o.store_data = rs2_val;
    assign ex_o.redirect   = id_ex_i.ctrl.branch && take;
    assign ex_o.target     = id_ex_i.pc + id_ex_i.imm;

endmodule

/* rtl/rv_branch_cmp.sv */
`timescale 1ns/1ps

module rv_branch_cmp (
    input  logic [2:0]  funct3_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic        take_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (funct3_i)
            3'b000:  take_o = eq;
            3'b001:  take_o = !eq;
            3'b100:  take_o = lt_s;
            3'b101:  take_o = !lt_s;
            3'b110:  take_o = lt_u;
            3'b111:  take_o = !lt_u;
            // 010 and 011 are not branches
            default: take_o = 1'b0;
        endcase
    end

endmodule

/* rtl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_e op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    output logic [31:0]     y_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:    y_o = a_i + b_i;
            rv_pkg::ALU_SUB:    y_o = a_i - b_i;
            rv_pkg::ALU_AND:    y_o = a_i & b_i;
            rv_pkg::ALU_OR:     y_o = a_i | b_i;
            rv_pkg::ALU_XOR:    y_o = a_i ^ b_i;
            rv_pkg::ALU_SLT:    y_o = {31'd0, $signed(a_i) < $signed(b_i)};
            rv_pkg::ALU_SLTU:   y_o = {31'd0, a_i < b_i};
            rv_pkg::ALU_SLL:    y_o = a_i << shamt;
            rv_pkg::ALU_SRL:    y_o = a_i >> shamt;
            rv_pkg::ALU_SRA:    y_o = $signed(a_i) >>> shamt;
            // lui
            rv_pkg::ALU_PASS_B: y_o = b_i;
            default:            y_o = 32'd0;
        endcase
    end

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR  = 32'h0000_0013;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    //////////////////////////////////////////////////
    // instruction formats
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    //////////////////////////////////////////////////
    // control and pipeline payloads
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_U} imm_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        imm_sel_e imm_sel;
        logic     src_imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        ctrl_t           ctrl;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
        logic [2:0]      funct3;
    } id_ex_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [4:0]      rd;
        logic [XLEN-1:0] result;
    } ex_wb_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] store_data;
        logic            redirect;
        logic [XLEN-1:0] target;
    } ex_out_t;

endpackage
